//--- nabp_lite.f
src/nabp_pkg.sv
src/nabp_itr_if.sv
src/nabp_swap_control.sv
src/nabp_state_control.sv
src/nabp_shifter.sv
src/nabp_mapper.sv
src/nabp_top.sv
verif/nabp_sva.sv
verif/nabp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the nabp testbench with Verilator, result goes to sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module nabp_tb \
    -f nabp_lite.f -o nabp_sim > sim.log 2>&1 \
    && ./obj_dir/nabp_sim >> sim.log 2>&1 \
    || echo ">>> FAIL" >> sim.log

! grep -q ">>> FAIL" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- src/nabp_itr_if.sv
`default_nettype none

interface nabp_itr_if
    import nabp_pkg::*;
();

    // data of one iteration
    angle_t angle;
    accu_t  line_cnt_fact;
    accu_t  sh_accu_base;
    accu_t  mp_accu_base;

    modport source (
        output angle,
        output line_cnt_fact,
        output sh_accu_base,
        output mp_accu_base
    );

    modport sink (
        input angle,
        input line_cnt_fact,
        input sh_accu_base,
        input mp_accu_base
    );

endinterface

`default_nettype wire

//--- src/nabp_mapper.sv
`default_nettype none

module nabp_mapper
    import nabp_pkg::*;
#(
    parameter int PE_WIDTH = 4
)
(
    input  logic    clk,
    input  logic    reset_n,
    nabp_itr_if.sink itr,
    input  logic    elem_valid,
    input  logic [$clog2(PE_WIDTH)-1:0] elem_index,
    input  sample_t elem_sample,
    output logic    map_valid,
    output angle_t  map_angle,
    output logic [$clog2(PE_WIDTH)-1:0] map_index,
    output map_t    map_value
);

    // i * line_cnt_fact, built up one element at a time
    map_t lc_term;
    map_t lc_now;

    // element 0 starts a new line
    always_comb
    begin
        if (elem_index == '0)
            lc_now = '0;
        else
            lc_now = lc_term;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            map_valid <= 1'b0;
        else
            map_valid <= elem_valid;
    end

    always_ff @(posedge clk)
    begin
        if (elem_valid)
        begin
            map_angle <= itr.angle;
            map_index <= elem_index;
            map_value <= map_t'(elem_sample) + itr.mp_accu_base + lc_now;
            lc_term   <= lc_now + itr.line_cnt_fact;
        end
    end

endmodule

`default_nettype wire

//--- src/nabp_pkg.sv
`default_nettype none

package nabp_pkg;

    // data widths
    localparam int SAMPLE_W = 12;
    localparam int ANGLE_W  = 8;
    localparam int ACCU_W   = 16;
    localparam int MAP_W    = 16;

    // one projection sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // angle index, so at most 256 angles per run
    typedef logic [ANGLE_W-1:0] angle_t;

    // accumulator bases and line count factor, wrapping
    typedef logic [ACCU_W-1:0] accu_t;

    // mapped result, wrapping
    typedef logic [MAP_W-1:0] map_t;

    // iteration phases of the state control
    typedef enum logic [2:0] {
        ready_s,
        fill_s,
        fill_done_s,
        shift_s,
        shift_done_s,
        setup_s
    } state_ctrl_e;

endpackage

`default_nettype wire

//--- src/nabp_shifter.sv
`default_nettype none

module nabp_shifter
    import nabp_pkg::*;
#(
    parameter int PE_WIDTH = 4
)
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    sh_fill_kick,
    input  logic    sh_shift_kick,
    nabp_itr_if.sink itr,
    input  logic    sample_valid,
    input  sample_t sample_data,
    output logic    sample_req,
    output logic    sh_fill_done,
    output logic    sh_shift_done,
    output logic    elem_valid,
    output logic [$clog2(PE_WIDTH)-1:0] elem_index,
    output sample_t elem_sample
);

    localparam int IDX_W = $clog2(PE_WIDTH);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(PE_WIDTH - 1);

    // samples in arrival order
    sample_t          sample_mem [PE_WIDTH];
    logic [IDX_W-1:0] fill_cnt;
    logic [IDX_W-1:0] rd_ptr;
    logic [IDX_W-1:0] out_cnt;
    logic             shifting;
    logic             accept;

    assign accept = sample_req && sample_valid;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sample_req    <= 1'b0;
            sh_fill_done  <= 1'b0;
            sh_shift_done <= 1'b0;
            elem_valid    <= 1'b0;
            shifting      <= 1'b0;
            fill_cnt      <= '0;
            rd_ptr        <= '0;
            out_cnt       <= '0;
        end
        else
        begin
            sh_fill_done  <= 1'b0;
            sh_shift_done <= 1'b0;
            elem_valid    <= 1'b0;

            // fill phase
            if (sh_fill_kick)
            begin
                sample_req <= 1'b1;
                fill_cnt   <= '0;
            end
            else if (accept)
            begin
                fill_cnt <= fill_cnt + 1'b1;
                if (fill_cnt == LAST_IDX)
                begin
                    sample_req   <= 1'b0;
                    sh_fill_done <= 1'b1;
                end
            end

            // shift phase, read pointer starts at the base offset and wraps
            if (sh_shift_kick)
            begin
                shifting <= 1'b1;
                out_cnt  <= '0;
                rd_ptr   <= IDX_W'(itr.sh_accu_base % accu_t'(PE_WIDTH));
            end
            else if (shifting)
            begin
                elem_valid <= 1'b1;
                rd_ptr     <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
                out_cnt    <= out_cnt + 1'b1;
                if (out_cnt == LAST_IDX)
                begin
                    shifting      <= 1'b0;
                    sh_shift_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            sample_mem[fill_cnt] <= sample_data;
        if (shifting)
        begin
            elem_index  <= out_cnt;
            elem_sample <= sample_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- src/nabp_state_control.sv
`default_nettype none

module nabp_state_control
    import nabp_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    nabp_itr_if.sink sw_itr,
    input  logic sw_next_itr_ack,
    input  logic sw_swap,
    input  logic run_done,
    input  logic sh_fill_done,
    input  logic sh_shift_done,
    nabp_itr_if.source mp_itr,
    output logic sw_next_itr,
    output logic sw_swap_ready,
    output logic sh_fill_kick,
    output logic sh_shift_kick,
    output logic done
);

    state_ctrl_e state;
    state_ctrl_e next_state;

    // set by the final swap, cleared when its iteration ends
    logic last_itr;

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (sw_next_itr_ack)
                    next_state = fill_s;
            fill_s:
                if (sh_fill_done)
                    next_state = fill_done_s;
            fill_done_s:
                if (sw_swap)
                    next_state = shift_s;
            shift_s:
                if (sh_shift_done)
                    next_state = shift_done_s;
            shift_done_s:
                next_state = setup_s;
            setup_s:
                next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // level requests towards swap control
    assign sw_next_itr   = (state == ready_s);
    assign sw_swap_ready = (state == fill_done_s);

    // kicks fire on the transition into fill and shift
    assign sh_fill_kick  = (state == ready_s) && sw_next_itr_ack;
    assign sh_shift_kick = (state == fill_done_s) && sw_swap;

    assign done = (state == setup_s) && last_itr;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state    <= ready_s;
            last_itr <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (run_done)
                last_itr <= 1'b1;
            else if (state == setup_s)
                last_itr <= 1'b0;
        end
    end

    // iteration data is taken once, on the ack
    always_ff @(posedge clk)
    begin
        if (sh_fill_kick)
        begin
            mp_itr.angle         <= sw_itr.angle;
            mp_itr.line_cnt_fact <= sw_itr.line_cnt_fact;
            mp_itr.sh_accu_base  <= sw_itr.sh_accu_base;
            mp_itr.mp_accu_base  <= sw_itr.mp_accu_base;
        end
    end

endmodule

`default_nettype wire

//--- src/nabp_swap_control.sv
`default_nettype none

module nabp_swap_control
    import nabp_pkg::*;
#(
    parameter int ANGLE_COUNT = 8,
    parameter int PE_WIDTH    = 4
)
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  start,
    input  accu_t shift_step,
    input  accu_t map_step,
    input  logic  sw_next_itr,
    input  logic  sw_swap_ready,
    output logic  sw_next_itr_ack,
    output logic  sw_swap,
    nabp_itr_if.source itr,
    output logic  run_done
);

    // one add per cycle: PE_WIDTH unit steps, then shift base, then map base
    localparam int CNT_W = $clog2(PE_WIDTH + 2);
    localparam logic [CNT_W-1:0] SH_STEP = CNT_W'(PE_WIDTH);
    localparam logic [CNT_W-1:0] MP_STEP = CNT_W'(PE_WIDTH + 1);
    localparam angle_t LAST_ANGLE = angle_t'(ANGLE_COUNT - 1);

    logic             active;
    logic             data_ready;
    logic             calc_busy;
    logic             last_acked;
    logic [CNT_W-1:0] calc_cnt;
    logic             issue_ack;
    logic             issue_swap;

    // itr holds the next angle and the sequencer asks for it
    assign issue_ack  = active && data_ready && sw_next_itr && !sw_next_itr_ack;
    // next angle computed, or nothing left to compute
    assign issue_swap = active && sw_swap_ready && !calc_busy && !sw_swap;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            active          <= 1'b0;
            data_ready      <= 1'b0;
            calc_busy       <= 1'b0;
            last_acked      <= 1'b0;
            calc_cnt        <= '0;
            sw_next_itr_ack <= 1'b0;
            sw_swap         <= 1'b0;
            run_done        <= 1'b0;
        end
        else
        begin
            sw_next_itr_ack <= issue_ack && !start;
            sw_swap         <= issue_swap && !start;
            run_done        <= issue_swap && last_acked && !start;
            if (start)
            begin
                // angle 0 is all zero, ready at once
                active     <= 1'b1;
                data_ready <= 1'b1;
                calc_busy  <= 1'b0;
                last_acked <= 1'b0;
                calc_cnt   <= '0;
            end
            else
            begin
                if (issue_ack)
                begin
                    data_ready <= 1'b0;
                    if (itr.angle == LAST_ANGLE)
                        last_acked <= 1'b1;
                    else
                    begin
                        calc_busy <= 1'b1;
                        calc_cnt  <= '0;
                    end
                end
                if (calc_busy)
                begin
                    calc_cnt <= calc_cnt + 1'b1;
                    if (calc_cnt == MP_STEP)
                    begin
                        calc_busy  <= 1'b0;
                        data_ready <= 1'b1;
                    end
                end
                if (issue_swap && last_acked)
                    active <= 1'b0;
            end
        end
    end

    // running sums, advanced while the current angle is in flight
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            itr.angle         <= '0;
            itr.line_cnt_fact <= '0;
            itr.sh_accu_base  <= '0;
            itr.mp_accu_base  <= '0;
        end
        else if (calc_busy)
        begin
            if (calc_cnt < SH_STEP)
                itr.line_cnt_fact <= itr.line_cnt_fact + accu_t'(1);
            else if (calc_cnt == SH_STEP)
                itr.sh_accu_base <= itr.sh_accu_base + shift_step;
            else
            begin
                itr.mp_accu_base <= itr.mp_accu_base + map_step;
                itr.angle        <= itr.angle + angle_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- src/nabp_top.sv
`default_nettype none

module nabp_top
    import nabp_pkg::*;
#(
    parameter int ANGLE_COUNT = 8,
    parameter int PE_WIDTH    = 4
)
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    start,
    output logic    sample_req,
    input  logic    sample_valid,
    input  sample_t sample_data,
    input  accu_t   shift_step,
    input  accu_t   map_step,
    output logic    map_valid,
    output angle_t  map_angle,
    output logic [$clog2(PE_WIDTH)-1:0] map_index,
    output map_t    map_value,
    output logic    done
);

    // strobes between the blocks
    logic    sw_next_itr;
    logic    sw_next_itr_ack;
    logic    sw_swap_ready;
    logic    sw_swap;
    logic    run_done;
    logic    sh_fill_kick;
    logic    sh_shift_kick;
    logic    sh_fill_done;
    logic    sh_shift_done;

    // shifter to mapper element stream
    logic    elem_valid;
    logic [$clog2(PE_WIDTH)-1:0] elem_index;
    sample_t elem_sample;

    // next angle from swap control, current angle from state control
    nabp_itr_if sw_itr ();
    nabp_itr_if mp_itr ();

    nabp_swap_control #(
        .ANGLE_COUNT (ANGLE_COUNT),
        .PE_WIDTH    (PE_WIDTH)
    ) u_swap_control (
        .itr (sw_itr),
        .*
    );

    nabp_state_control u_state_control (.*);

    nabp_shifter #(
        .PE_WIDTH (PE_WIDTH)
    ) u_shifter (
        .itr (mp_itr),
        .*
    );

    nabp_mapper #(
        .PE_WIDTH (PE_WIDTH)
    ) u_mapper (
        .itr (mp_itr),
        .*
    );

endmodule

`default_nettype wire

//--- verif/nabp_sva.sv
`default_nettype none

module nabp_sva
    import nabp_pkg::*;
(
    input logic        clk,
    input logic        reset_n,
    input state_ctrl_e state,
    input logic        sh_fill_kick,
    input logic        sh_shift_kick,
    input logic        sw_swap_ready,
    input logic        sh_shift_done,
    input logic        done
);
    timeunit 1ns;
    timeprecision 100ps;

    // kicks last one cycle and never overlap
    assert property (@(posedge clk) disable iff (!reset_n) sh_fill_kick |=> !sh_fill_kick)
        else $error("sh_fill_kick longer than one cycle");
    assert property (@(posedge clk) disable iff (!reset_n) sh_shift_kick |=> !sh_shift_kick)
        else $error("sh_shift_kick longer than one cycle");
    assert property (@(posedge clk) disable iff (!reset_n) !(sh_fill_kick && sh_shift_kick))
        else $error("fill and shift kicks in the same cycle");

    // swap request is held until the swap arrives
    assert property (@(posedge clk) disable iff (!reset_n)
        (sw_swap_ready && !sh_shift_kick) |=> sw_swap_ready)
        else $error("sw_swap_ready dropped before the swap");

    // through shift_done_s and setup_s, then back to ready
    assert property (@(posedge clk) disable iff (!reset_n)
        sh_shift_done |-> ##3 (state == ready_s))
        else $error("no return to ready_s after sh_shift_done");

    // done is a single pulse that ends the iteration
    assert property (@(posedge clk) disable iff (!reset_n)
        done |=> (state == ready_s) && !done)
        else $error("done not followed by ready_s or longer than one cycle");

endmodule

bind nabp_state_control nabp_sva u_sva (
    .clk           (clk),
    .reset_n       (reset_n),
    .state         (state),
    .sh_fill_kick  (sh_fill_kick),
    .sh_shift_kick (sh_shift_kick),
    .sw_swap_ready (sw_swap_ready),
    .sh_shift_done (sh_shift_done),
    .done          (done)
);

`default_nettype wire

//--- verif/nabp_tb.sv
`default_nettype none

module nabp_tb
    import nabp_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ANGLE_COUNT = 8;
    localparam int PE_WIDTH    = 4;
    localparam int IDX_W       = $clog2(PE_WIDTH);
    localparam int TOTAL       = ANGLE_COUNT * PE_WIDTH;
    localparam int NUM_TESTS   = 7;
    localparam int POOL_SIZE   = 512;
    localparam int TIMEOUT     = 2000;

    typedef struct packed {
        accu_t shift_step;
        accu_t map_step;
        int    gap;
    } test_row_t;

    logic             clk          = 1'b0;
    logic             reset_n;
    logic             start;
    logic             sample_req;
    logic             sample_valid = 1'b0;
    sample_t          sample_data  = '0;
    accu_t            shift_step;
    accu_t            map_step;
    logic             map_valid;
    angle_t           map_angle;
    logic [IDX_W-1:0] map_index;
    map_t             map_value;
    logic             done;

    test_row_t tests [NUM_TESTS];
    sample_t   sample_pool [POOL_SIZE];
    // every sample the DUT took, over all tests
    sample_t   accepted [$];
    int        pool_idx     = 0;
    int        idle_cnt     = 0;
    logic      req_drop_due = 1'b0;
    int        cur_test     = 0;
    int        sample_base  = 0;
    int        result_base  = 0;
    int        result_cnt   = 0;
    int        done_cnt     = 0;
    int        map_errs     = 0;
    int        feed_errs    = 0;
    int        main_errs    = 0;

    nabp_top #(
        .ANGLE_COUNT (ANGLE_COUNT),
        .PE_WIDTH    (PE_WIDTH)
    ) dut (.*);

    always #5 clk = ~clk;

    // element i of angle a, built from the per-angle and output rules
    function automatic map_t expected_value(input int a, input int i);
        accu_t sh_base;
        accu_t mp_base;
        accu_t lc_fact;
        int    pick;
        sh_base = accu_t'(a * int'(tests[cur_test].shift_step));
        mp_base = accu_t'(a * int'(tests[cur_test].map_step));
        lc_fact = accu_t'(a * PE_WIDTH);
        pick    = sample_base + a * PE_WIDTH + (i + int'(sh_base) % PE_WIDTH) % PE_WIDTH;
        return map_t'(accepted[pick]) + mp_base + accu_t'(i * int'(lc_fact));
    endfunction

    function automatic int total_errors();
        return map_errs + feed_errs + main_errs;
    endfunction

    // sample source, holds valid and data until taken, then idles for the gap
    always @(posedge clk)
    begin : sample_feeder
        if (!reset_n)
        begin
            sample_valid <= 1'b0;
            idle_cnt     = 0;
            req_drop_due = 1'b0;
        end
        else
        begin
            if (req_drop_due)
            begin
                assert (!sample_req)
                else
                begin
                    $display("Error at %0t: sample_req still high after a full line", $time);
                    feed_errs++;
                end
                req_drop_due = 1'b0;
            end
            if (sample_valid && sample_req)
            begin
                accepted.push_back(sample_data);
                pool_idx     = (pool_idx + 1) % POOL_SIZE;
                req_drop_due = (accepted.size() % PE_WIDTH == 0);
                if (tests[cur_test].gap == 0)
                    sample_data <= sample_pool[pool_idx];
                else
                begin
                    sample_valid <= 1'b0;
                    idle_cnt     = tests[cur_test].gap;
                end
            end
            else if (!sample_valid)
            begin
                if (idle_cnt > 0)
                    idle_cnt--;
                if (idle_cnt == 0)
                begin
                    sample_valid <= 1'b1;
                    sample_data  <= sample_pool[pool_idx];
                end
            end
        end
    end

    // checks every mapped result and the done pulse
    always @(posedge clk)
    begin : result_monitor
        int   r;
        int   a;
        int   i;
        logic have_samples;
        map_t exp_value;
        if (reset_n && map_valid)
        begin
            r = result_cnt - result_base;
            a = r / PE_WIDTH;
            i = r % PE_WIDTH;
            have_samples = (r < TOTAL) && (accepted.size() >= sample_base + (a + 1) * PE_WIDTH);
            assert (have_samples)
            else
            begin
                $display("Error at %0t: result %0d came without its samples", $time, r);
                map_errs++;
            end
            if (have_samples)
            begin
                exp_value = expected_value(a, i);
                assert (map_angle == angle_t'(a))
                else
                begin
                    $display("Mismatch at %0t: map_angle expected %0d, got %0d", $time, a, map_angle);
                    map_errs++;
                end
                assert (map_index == IDX_W'(i))
                else
                begin
                    $display("Mismatch at %0t: map_index expected %0d, got %0d", $time, i, map_index);
                    map_errs++;
                end
                assert (map_value == exp_value)
                else
                begin
                    $display("Mismatch at %0t: map_value expected %h, got %h",
                        $time, exp_value, map_value);
                    map_errs++;
                end
            end
            result_cnt++;
        end
        if (reset_n && done)
        begin
            done_cnt++;
            assert (result_cnt - result_base == TOTAL)
            else
            begin
                $display("Error at %0t: done came before all results", $time);
                map_errs++;
            end
        end
    end

    initial
    begin
        int   cycles;
        int   done_base;
        int   errs_before;
        int   results;
        int   dones;
        int   tests_run;
        int   tests_failed;
        logic timed_out;
        void'($urandom(32'h82b5_d6c7));
        for (int k = 0; k < POOL_SIZE; k++)
            sample_pool[k] = sample_t'($urandom);

        // zero steps, rotation, wraparound, slow sources
        tests[0] = '{shift_step: 16'h0000, map_step: 16'h0000, gap: 0};
        tests[1] = '{shift_step: 16'h0001, map_step: 16'h0010, gap: 1};
        tests[2] = '{shift_step: 16'h0003, map_step: 16'h0101, gap: 0};
        tests[3] = '{shift_step: 16'h0007, map_step: 16'h1234, gap: 3};
        tests[4] = '{shift_step: 16'hffff, map_step: 16'hf00d, gap: 1};
        tests[5] = '{shift_step: 16'h8003, map_step: 16'hfff0, gap: 3};
        tests[6] = '{shift_step: 16'h0000, map_step: 16'h0000, gap: 3};

        reset_n    = 1'b0;
        start      = 1'b0;
        shift_step = '0;
        map_step   = '0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        // no activity before the first start
        repeat (6)
        begin
            @(posedge clk);
            assert (!sample_req && !map_valid && !done)
            else
            begin
                $display("Error at %0t: control output high before start", $time);
                main_errs++;
            end
        end

        for (int t = 0; t < NUM_TESTS && !timed_out; t++)
        begin
            @(posedge clk);
            cur_test    = t;
            sample_base = accepted.size();
            result_base = result_cnt;
            done_base   = done_cnt;
            errs_before = total_errors();
            shift_step <= tests[t].shift_step;
            map_step   <= tests[t].map_step;
            start      <= 1'b1;
            @(posedge clk);
            start <= 1'b0;

            cycles = 0;
            while (!done && cycles < TIMEOUT)
            begin
                @(posedge clk);
                cycles++;
            end
            assert (done)
            else
            begin
                $display("Error at %0t: timed out waiting for done in test %0d", $time, t);
                main_errs++;
                timed_out = 1'b1;
            end

            // let stray results or a second done show up
            repeat (12) @(posedge clk);
            results = result_cnt - result_base;
            dones   = done_cnt - done_base;
            assert (results == TOTAL)
            else
            begin
                $display("Error at %0t: %0d results instead of %0d", $time, results, TOTAL);
                main_errs++;
            end
            assert (dones == 1)
            else
            begin
                $display("Error at %0t: done pulsed %0d times", $time, dones);
                main_errs++;
            end

            tests_run++;
            if (total_errors() != errs_before)
                tests_failed++;
            $display("test %0d: shift_step %h map_step %h gap %0d, %0d results, %0d errors",
                t, tests[t].shift_step, tests[t].map_step, tests[t].gap, results,
                total_errors() - errs_before);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
            total_errors());
        if (total_errors() == 0 && !timed_out)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
